/* hdl/exu_cfg_pkg.sv */
package exu_cfg_pkg;

   // datapath width
   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;

   // RV32M: x / 0 gives all ones in both signed and unsigned form
   localparam word_t DIV_ZERO_QUOT = '1;

   // link address increments
   localparam word_t INSN_STEP  = 32'd4;   // full-size instruction
   localparam word_t CINSN_STEP = 32'd2;   // compressed instruction

endpackage

/* hdl/alu_op_pkg.sv */
package alu_op_pkg;

   typedef enum logic [5:0] {
      ADD,
      ADDI,
      SUB,
      AND,
      ANDI,
      OR,
      ORI,
      XOR,
      XORI,
      SLL,
      SLLI,
      SRL,
      SRLI,
      SRA,
      SRAI,
      SLT,
      SLTI,
      SLTU,
      SLTIU,
      LUI,
      AUIPC,
      JAL,
      JALR,
      MEM,        // load/store address
      MUL,
      MULH,
      MULHSU,
      MULHU,
      DIV,
      DIVU,
      REM,
      REMU
   } alu_op_e;

   typedef enum logic [1:0] {
      LOW,        // low word, signedness does not matter
      HIGH_SS,
      HIGH_SU,
      HIGH_UU
   } mul_kind_e;

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DONE
   } div_state_e;

endpackage

/* hdl/muldiv_if.sv */
interface mul_if;
   import exu_cfg_pkg::*;
   import alu_op_pkg::*;

   logic      valid;
   mul_kind_e kind;
   word_t     a;
   word_t     b;
   word_t     product;
   logic      done;      // two cycles after valid

   modport master (
      output valid, kind, a, b,
      input  product, done
   );

   modport slave (
      input  valid, kind, a, b,
      output product, done
   );

endinterface

interface div_if;
   import exu_cfg_pkg::*;

   logic  req;           // held until done
   logic  is_signed;
   word_t dividend;
   word_t divisor;
   word_t quotient;
   word_t remainder;
   logic  done;

   modport master (
      output req, is_signed, dividend, divisor,
      input  quotient, remainder, done
   );

   modport slave (
      input  req, is_signed, dividend, divisor,
      output quotient, remainder, done
   );

endinterface

/* hdl/int_multiplier.sv */
module int_multiplier (
   input  logic clk_i,
   input  logic rst_i,
   mul_if.slave mul
);
   import exu_cfg_pkg::*;
   import alu_op_pkg::*;

   logic [1:0]               vld_q;      // valid per stage
   logic                     a_sgn;
   logic                     b_sgn;
   logic signed [XLEN:0]     a_q;        // operands with one extension bit
   logic signed [XLEN:0]     b_q;
   logic                     high_q;
   logic signed [2*XLEN+1:0] full_w;
   word_t                    product_q;

   always_comb begin
      a_sgn = (mul.kind == HIGH_SS) || (mul.kind == HIGH_SU);
      b_sgn = (mul.kind == HIGH_SS);
   end

   // stage one
   always_ff @(posedge clk_i) begin
      if (mul.valid) begin
         a_q    <= {a_sgn & mul.a[XLEN-1], mul.a};
         b_q    <= {b_sgn & mul.b[XLEN-1], mul.b};
         high_q <= (mul.kind != LOW);
      end
   end

   assign full_w = a_q * b_q;

   // stage two
   always_ff @(posedge clk_i) begin
      if (vld_q[0]) begin
         product_q <= high_q ? full_w[2*XLEN-1:XLEN] : full_w[XLEN-1:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[0], mul.valid};
      end
   end

   assign mul.product = product_q;
   assign mul.done    = vld_q[1];

endmodule

/* hdl/int_divider.sv */
module int_divider (
   input  logic clk_i,
   input  logic rst_i,
   div_if.slave div
);
   import exu_cfg_pkg::*;
   import alu_op_pkg::*;

   localparam int STEP_W = $clog2(XLEN);

   div_state_e        state_q;
   logic [STEP_W-1:0] step_q;
   word_t             quo_q;       // dividend shifts out, quotient shifts in
   word_t             rem_q;
   word_t             dvs_q;
   logic              quo_neg_q;
   logic              rem_neg_q;

   logic              dvd_neg;
   logic              dvs_neg;
   word_t             dvd_abs;
   word_t             dvs_abs;
   logic              div_zero;
   logic [XLEN:0]     shifted;
   logic [XLEN+1:0]   trial;
   logic              borrow;

   always_comb begin
      dvd_neg  = div.is_signed & div.dividend[XLEN-1];
      dvs_neg  = div.is_signed & div.divisor[XLEN-1];
      dvd_abs  = dvd_neg ? -div.dividend : div.dividend;
      dvs_abs  = dvs_neg ? -div.divisor : div.divisor;
      div_zero = (div.divisor == '0);
   end

   // one restoring step
   assign shifted = {rem_q, quo_q[XLEN-1]};
   assign trial   = {1'b0, shifted} - {2'b00, dvs_q};
   assign borrow  = trial[XLEN+1];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q <= IDLE;
         step_q  <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               step_q <= '0;
               if (div.req) begin
                  if (div_zero) begin
                     state_q <= DONE;    // no iterations needed
                  end else begin
                     state_q <= RUN;
                  end
               end
            end
            RUN: begin
               step_q <= step_q + 1'b1;
               if (step_q == STEP_W'(XLEN-1)) begin
                  state_q <= DONE;
               end
            end
            DONE: state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == IDLE && div.req) begin
         dvs_q <= dvs_abs;
         if (div_zero) begin
            quo_q     <= DIV_ZERO_QUOT;
            rem_q     <= div.dividend;
            quo_neg_q <= 1'b0;
            rem_neg_q <= 1'b0;
         end else begin
            quo_q     <= dvd_abs;
            rem_q     <= '0;
            quo_neg_q <= dvd_neg ^ dvs_neg;
            rem_neg_q <= dvd_neg;      // remainder takes the dividend sign
         end
      end else if (state_q == RUN) begin
         quo_q <= {quo_q[XLEN-2:0], ~borrow};
         rem_q <= borrow ? shifted[XLEN-1:0] : trial[XLEN-1:0];
      end
   end

   assign div.quotient  = quo_neg_q ? -quo_q : quo_q;
   assign div.remainder = rem_neg_q ? -rem_q : rem_q;
   assign div.done      = (state_q == DONE);

   // a result only answers a request the core still holds
   a_done_with_req: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      div.done |-> div.req
   );

endmodule

/* hdl/alu_core.sv */
module alu_core (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                hold_i,
   input  logic                issue_i,
   input  alu_op_pkg::alu_op_e op_i,
   input  exu_cfg_pkg::word_t  rs1_i,
   input  exu_cfg_pkg::word_t  rs2_i,
   input  exu_cfg_pkg::word_t  imm_i,
   input  exu_cfg_pkg::word_t  pc_i,
   input  logic                compressed_i,
   output exu_cfg_pkg::word_t  result_o,
   output logic                ready_o,
   output logic                stall_o,
   output exu_cfg_pkg::word_t  jump_target_o,
   output logic                jump_valid_o,
   output logic                eq_o,
   output logic                lt_o,
   output logic                ltu_o,
   mul_if.master               mul,
   div_if.master               div
);
   import exu_cfg_pkg::*;
   import alu_op_pkg::*;

   word_t      result_q;
   word_t      result_d;
   logic       ready_q;
   logic       ready_d;
   logic [1:0] mul_cnt_q;     // 0 idle, 1..2 product in flight
   logic       div_busy_q;
   logic       div_rem_q;     // remainder wanted, not quotient

   logic       is_mul;
   logic       is_div;
   logic       idle;
   logic       go;
   logic       mul_start;
   logic       div_start;
   word_t      link_addr;

   assign is_mul    = op_i inside {MUL, MULH, MULHSU, MULHU};
   assign is_div    = op_i inside {DIV, DIVU, REM, REMU};
   assign idle      = (mul_cnt_q == 2'd0) && !div_busy_q;
   assign go        = issue_i && idle && !hold_i;
   assign mul_start = go && is_mul;
   assign div_start = go && is_div;
   assign link_addr = pc_i + (compressed_i ? CINSN_STEP : INSN_STEP);

   // branch compare and jump target straight from the inputs
   assign eq_o          = (rs1_i == rs2_i);
   assign lt_o          = ($signed(rs1_i) < $signed(rs2_i));
   assign ltu_o         = (rs1_i < rs2_i);
   assign jump_valid_o  = issue_i && (op_i == JAL || op_i == JALR);
   assign jump_target_o = (op_i == JALR) ? rs1_i + imm_i : pc_i + imm_i;

   assign mul.valid = mul_start;
   assign mul.a     = rs1_i;
   assign mul.b     = rs2_i;

   always_comb begin
      case (op_i)
         MULH:    mul.kind = HIGH_SS;
         MULHSU:  mul.kind = HIGH_SU;
         MULHU:   mul.kind = HIGH_UU;
         default: mul.kind = LOW;
      endcase
   end

   assign div.req       = div_start || div_busy_q;   // kept up until done
   assign div.is_signed = (op_i == DIV) || (op_i == REM);
   assign div.dividend  = rs1_i;
   assign div.divisor   = rs2_i;

   assign stall_o = mul_start || div_start
                 || ((mul_cnt_q != 2'd0) && !mul.done)
                 || (div_busy_q && !div.done);

   always_comb begin
      result_d = result_q;
      ready_d  = 1'b0;
      if (mul.done) begin
         result_d = mul.product;
         ready_d  = 1'b1;
      end else if (div_busy_q && div.done) begin
         result_d = div_rem_q ? div.remainder : div.quotient;
         ready_d  = 1'b1;
      end else if (go && !is_mul && !is_div) begin
         ready_d = 1'b1;
         case (op_i)
            ADD:     result_d = rs1_i + rs2_i;
            ADDI:    result_d = rs1_i + imm_i;
            SUB:     result_d = rs1_i - rs2_i;
            AND:     result_d = rs1_i & rs2_i;
            ANDI:    result_d = rs1_i & imm_i;
            OR:      result_d = rs1_i | rs2_i;
            ORI:     result_d = rs1_i | imm_i;
            XOR:     result_d = rs1_i ^ rs2_i;
            XORI:    result_d = rs1_i ^ imm_i;
            SLL:     result_d = rs1_i << rs2_i[4:0];
            SLLI:    result_d = rs1_i << imm_i[4:0];
            SRL:     result_d = rs1_i >> rs2_i[4:0];
            SRLI:    result_d = rs1_i >> imm_i[4:0];
            SRA:     result_d = $signed(rs1_i) >>> rs2_i[4:0];
            SRAI:    result_d = $signed(rs1_i) >>> imm_i[4:0];
            SLT:     result_d = word_t'($signed(rs1_i) < $signed(rs2_i));
            SLTI:    result_d = word_t'($signed(rs1_i) < $signed(imm_i));
            SLTU:    result_d = word_t'(rs1_i < rs2_i);
            SLTIU:   result_d = word_t'(rs1_i < imm_i);
            LUI:     result_d = imm_i;
            AUIPC:   result_d = pc_i + imm_i;
            JAL,
            JALR:    result_d = link_addr;
            MEM:     result_d = rs1_i + imm_i;   // effective address
            default: ready_d  = 1'b0;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         result_q <= '0;
         ready_q  <= 1'b0;
      end else if (!hold_i) begin
         result_q <= result_d;
         ready_q  <= ready_d;
      end
   end

   // sub-unit tracking runs on since the units do not see hold_i
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         mul_cnt_q  <= 2'd0;
         div_busy_q <= 1'b0;
         div_rem_q  <= 1'b0;
      end else begin
         if (mul_start) begin
            mul_cnt_q <= 2'd1;
         end else if (mul_cnt_q != 2'd0) begin
            mul_cnt_q <= mul.done ? 2'd0 : mul_cnt_q + 2'd1;
         end

         if (div_start) begin
            div_busy_q <= 1'b1;
            div_rem_q  <= (op_i == REM) || (op_i == REMU);
         end else if (div.done) begin
            div_busy_q <= 1'b0;
         end
      end
   end

   assign result_o = result_q;
   assign ready_o  = ready_q;

   // while a multiply or divide is in flight no result is presented
   a_stall_ready_excl: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      (stall_o && (mul_cnt_q != 2'd0 || div_busy_q)) |-> !ready_o
   );

   // divider sees a steady request and steady operands until it answers
   a_div_req_held: assert property (
      @(posedge clk_i) disable iff (!rst_i)
      (div.req && stall_o) |=> div.req && $stable(div.dividend)
                              && $stable(div.divisor) && $stable(div.is_signed)
   );

endmodule

/* hdl/exec_unit_top.sv */
module exec_unit_top (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                hold_i,
   input  logic                issue_i,
   input  alu_op_pkg::alu_op_e op_i,
   input  exu_cfg_pkg::word_t  rs1_i,
   input  exu_cfg_pkg::word_t  rs2_i,
   input  exu_cfg_pkg::word_t  imm_i,
   input  exu_cfg_pkg::word_t  pc_i,
   input  logic                compressed_i,
   output exu_cfg_pkg::word_t  result_o,
   output logic                ready_o,
   output logic                stall_o,
   output exu_cfg_pkg::word_t  jump_target_o,
   output logic                jump_valid_o,
   output logic                eq_o,
   output logic                lt_o,
   output logic                ltu_o
);

   mul_if mul_bus ();
   div_if div_bus ();

   alu_core u_alu_core (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hold_i        (hold_i),
      .issue_i       (issue_i),
      .op_i          (op_i),
      .rs1_i         (rs1_i),
      .rs2_i         (rs2_i),
      .imm_i         (imm_i),
      .pc_i          (pc_i),
      .compressed_i  (compressed_i),
      .result_o      (result_o),
      .ready_o       (ready_o),
      .stall_o       (stall_o),
      .jump_target_o (jump_target_o),
      .jump_valid_o  (jump_valid_o),
      .eq_o          (eq_o),
      .lt_o          (lt_o),
      .ltu_o         (ltu_o),
      .mul           (mul_bus.master),
      .div           (div_bus.master)
   );

   int_multiplier u_int_multiplier (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .mul   (mul_bus.slave)
   );

   int_divider u_int_divider (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .div   (div_bus.slave)
   );

endmodule

/* verification/exec_ref_model.svh */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// expected result_o for one issued operation, RV32I and RV32M rules
function automatic word_t ref_result(alu_op_e op, word_t a, word_t b, word_t imm,
                                     word_t pc, logic compressed);
   logic [63:0] prod;
   logic [4:0]  sh;
   logic        ovf;
   word_t       r;
   sh  = (op inside {SLLI, SRLI, SRAI}) ? imm[4:0] : b[4:0];
   ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);   // most negative / -1
   case (op)
      MULH:    prod = longint'($signed(a)) * longint'($signed(b));
      MULHSU:  prod = longint'($signed(a)) * longint'({32'd0, b});
      default: prod = 64'(a) * 64'(b);
   endcase
   r = '0;
   case (op)
      ADD:              r = a + b;
      ADDI, MEM:        r = a + imm;
      SUB:              r = a - b;
      AND:              r = a & b;
      ANDI:             r = a & imm;
      OR:               r = a | b;
      ORI:              r = a | imm;
      XOR:              r = a ^ b;
      XORI:             r = a ^ imm;
      SLL, SLLI:        r = a << sh;
      SRL, SRLI:        r = a >> sh;
      SRA, SRAI:        r = $signed(a) >>> sh;
      SLT:              r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTI:             r = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
      SLTU:             r = (a < b) ? 32'd1 : 32'd0;
      SLTIU:            r = (a < imm) ? 32'd1 : 32'd0;
      LUI:              r = imm;
      AUIPC:            r = pc + imm;
      JAL, JALR:        r = pc + (compressed ? 32'd2 : 32'd4);   // link address
      MUL:              r = prod[31:0];
      MULH, MULHSU,
      MULHU:            r = prod[63:32];
      DIV: begin
         if (b == '0) r = 32'hffff_ffff;
         else if (ovf) r = a;
         else r = $signed(a) / $signed(b);
      end
      DIVU:             r = (b == '0) ? 32'hffff_ffff : a / b;
      REM: begin
         if (b == '0) r = a;
         else if (ovf) r = '0;
         else r = $signed(a) % $signed(b);
      end
      REMU:             r = (b == '0) ? a : a % b;
      default:          r = '0;
   endcase
   return r;
endfunction

function automatic word_t ref_target(alu_op_e op, word_t a, word_t imm, word_t pc);
   return (op == JALR) ? a + imm : pc + imm;
endfunction

// {eq, lt, ltu}
function automatic logic [2:0] ref_flags(word_t a, word_t b);
   return {a == b, $signed(a) < $signed(b), a < b};
endfunction

`endif

/* verification/tb_exec_unit.sv */
module tb_exec_unit;
   timeunit 1ns;
   timeprecision 1ps;
   import exu_cfg_pkg::*;
   import alu_op_pkg::*;

   `include "exec_ref_model.svh"

   localparam int WAIT_LIMIT = 60;    // cycles per operation
   localparam int NUM_RANDOM = 400;

   logic    clk_i;
   logic    rst_i;
   logic    hold_i;
   logic    issue_i;
   alu_op_e op_i;
   word_t   rs1_i;
   word_t   rs2_i;
   word_t   imm_i;
   word_t   pc_i;
   logic    compressed_i;
   word_t   result_o;
   logic    ready_o;
   logic    stall_o;
   word_t   jump_target_o;
   logic    jump_valid_o;
   logic    eq_o;
   logic    lt_o;
   logic    ltu_o;

   int      value_errs;
   int      timeout_errs;

   exec_unit_top u_exec_unit_top (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .hold_i        (hold_i),
      .issue_i       (issue_i),
      .op_i          (op_i),
      .rs1_i         (rs1_i),
      .rs2_i         (rs2_i),
      .imm_i         (imm_i),
      .pc_i          (pc_i),
      .compressed_i  (compressed_i),
      .result_o      (result_o),
      .ready_o       (ready_o),
      .stall_o       (stall_o),
      .jump_target_o (jump_target_o),
      .jump_valid_o  (jump_valid_o),
      .eq_o          (eq_o),
      .lt_o          (lt_o),
      .ltu_o         (ltu_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic check_result(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR @ %0t ns: %s result %h, expected %h", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_target(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR @ %0t ns: %s target %h, expected %h", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_flags(input logic [2:0] got, input logic [2:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("ERROR @ %0t ns: %s eq/lt/ltu %b, expected %b", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERROR @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_latency(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("ERROR @ %0t ns: %s ready after %0d cycles, expected %0d",
                  $time, what, got, exp);
         value_errs++;
      end
   endtask

   // operands biased toward signs and extreme values
   function automatic word_t rand_operand();
      case ($urandom_range(0, 7))
         0: return 32'h0000_0000;
         1: return 32'h0000_0001;
         2: return 32'hffff_ffff;
         3: return 32'h8000_0000;
         4: return 32'h7fff_ffff;
         5: return $urandom() | 32'h8000_0000;
         default: return $urandom();
      endcase
   endfunction

   // drive one operation on the falling edge and wait for its result
   task automatic run_op(input alu_op_e op, input word_t a, input word_t b,
                         input word_t imm, input word_t pc, input logic comp);
      word_t exp_res;
      logic  is_jump;
      logic  is_long;
      int    exp_lat;
      int    n;
      string tag;
      exp_res = ref_result(op, a, b, imm, pc, comp);
      is_jump = (op == JAL) || (op == JALR);
      is_long = op inside {MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
      if (op inside {MUL, MULH, MULHSU, MULHU}) exp_lat = 3;
      else if (is_long) exp_lat = (b == '0) ? 2 : 34;
      else exp_lat = 1;
      tag = op.name();
      op_i         = op;
      rs1_i        = a;
      rs2_i        = b;
      imm_i        = imm;
      pc_i         = pc;
      compressed_i = comp;
      issue_i      = 1'b1;
      #1;
      check_flags({eq_o, lt_o, ltu_o}, ref_flags(a, b), tag);
      check_bit(jump_valid_o, is_jump, {tag, " jump_valid_o"});
      if (is_jump) check_target(jump_target_o, ref_target(op, a, imm, pc), tag);
      check_bit(stall_o, is_long, {tag, " stall_o at issue"});
      n = 0;
      while (1) begin
         @(negedge clk_i);
         n++;
         check_bit(stall_o, is_long && (n < exp_lat - 1), {tag, " stall_o"});
         if (!stall_o) issue_i = 1'b0;   // accepted so inputs may change
         if (ready_o) break;
         if (n >= WAIT_LIMIT) begin
            $display("timeout: %s gave no ready_o within %0d cycles", tag, WAIT_LIMIT);
            timeout_errs++;
            break;
         end
      end
      issue_i = 1'b0;
      if (ready_o) begin
         check_result(result_o, exp_res, tag);
         check_latency(n, exp_lat, tag);
      end
   endtask

   task automatic hold_result(input int cycles);
      word_t kept;
      logic  kept_rdy;
      kept     = result_o;
      kept_rdy = ready_o;
      hold_i   = 1'b1;
      repeat (cycles) begin
         @(negedge clk_i);
         check_result(result_o, kept, "held");
         check_bit(ready_o, kept_rdy, "held ready_o");
      end
      hold_i = 1'b0;
   endtask

   initial begin
      alu_op_e rand_op;
      void'($urandom(42));
      value_errs   = 0;
      timeout_errs = 0;
      rst_i        = 1'b0;
      hold_i       = 1'b0;
      issue_i      = 1'b0;
      op_i         = ADD;
      rs1_i        = '0;
      rs2_i        = '0;
      imm_i        = '0;
      pc_i         = '0;
      compressed_i = 1'b0;
      repeat (3) @(negedge clk_i);
      check_result(result_o, '0, "reset");
      check_bit(ready_o, 1'b0, "reset ready_o");
      check_bit(stall_o, 1'b0, "reset stall_o");
      check_bit(jump_valid_o, 1'b0, "reset jump_valid_o");
      rst_i = 1'b1;
      @(negedge clk_i);

      // every operation once
      for (int k = 0; k <= int'(REMU); k++) begin
         run_op(alu_op_e'(k), rand_operand(), rand_operand(), $urandom(),
                $urandom() & 32'hffff_fffc, 1'($urandom_range(0, 1)));
      end

      // division by zero and signed overflow
      for (int k = int'(DIV); k <= int'(REMU); k++) begin
         run_op(alu_op_e'(k), rand_operand(), 32'd0, '0, '0, 1'b0);
         run_op(alu_op_e'(k), 32'h8000_0000, 32'hffff_ffff, '0, '0, 1'b0);
      end

      for (int i = 0; i < NUM_RANDOM; i++) begin
         rand_op = alu_op_e'($urandom_range(0, 31));
         run_op(rand_op, rand_operand(), rand_operand(), rand_operand(),
                $urandom() & 32'hffff_fffe, 1'($urandom_range(0, 1)));
         if ($urandom_range(0, 7) == 0) hold_result($urandom_range(1, 4));
      end

      $display("summary: %0d value errors, %0d timeouts", value_errs, timeout_errs);
      if (value_errs == 0 && timeout_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
+incdir+verification
hdl/exu_cfg_pkg.sv
hdl/alu_op_pkg.sv
hdl/muldiv_if.sv
hdl/int_multiplier.sv
hdl/int_divider.sv
hdl/alu_core.sv
hdl/exec_unit_top.sv
verification/tb_exec_unit.sv
